// File: hw/tcb_conv_consts.svh
// TCB converter constants
// bus geometry and memory depth for the reference to memory
// converter and its byte-enabled memory

`ifndef TCB_CONV_CONSTS_SVH
`define TCB_CONV_CONSTS_SVH

////////////////////
// bus geometry
////////////////////

// byte address width
`define TCB_ADR_W 16
// bytes per bus word
`define TCB_BEW 4
// bits per byte
`define TCB_SLW 8
// byte offset within a word, log2 of TCB_BEW
`define TCB_OFS_W 2

////////////////////
// memory
////////////////////

// depth in words
`define TCB_MEM_WORDS 256

`endif

// File: hw/tcb_pkg.sv
// TCB converter package
// vector types with a meaning and the request and response
// structs shared by the converter, the memory and the testbench

`include "tcb_conv_consts.svh"

package tcb_pkg;

  ////////////////////
  // vector types
  ////////////////////

  // byte address
  typedef logic [`TCB_ADR_W-1:0] adr_t;
  // bus data word, little end in the low byte
  typedef logic [`TCB_BEW*`TCB_SLW-1:0] dat_t;
  // byte enables, one per lane
  typedef logic [`TCB_BEW-1:0] ben_t;
  // log2 of transfer bytes, 3 is illegal
  typedef logic [1:0] siz_t;
  // byte offset within a word
  typedef logic [`TCB_OFS_W-1:0] ofs_t;

  ////////////////////
  // structs
  ////////////////////

  // reference mode request from the manager
  // data always sits in the low bytes
  typedef struct packed {
    logic wen;
    logic ndn;
    siz_t siz;
    adr_t adr;
    dat_t wdt;
  } tcb_req_t;

  // memory mode request, data on its own lanes
  typedef struct packed {
    logic wen;
    adr_t adr;
    ben_t ben;
    dat_t wdt;
  } tcb_mreq_t;

  // response, one cycle after the request
  typedef struct packed {
    dat_t rdt;
    logic err;
  } tcb_rsp_t;

endpackage

// File: hw/tcb_align_check.sv
// TCB alignment check
// flags accesses whose size does not fit the low address bits
// and forms the word-aligned address for the memory

`timescale 1ns/1ns

`include "tcb_conv_consts.svh"

module tcb_align_check
  import tcb_pkg::*;
(
  input  tcb_req_t req,
  output logic     mal,
  output adr_t     adr
);

  ////////////////////
  // misalignment
  ////////////////////

  // same decode for reads and writes
  always_comb begin
    case (req.siz)
      // single byte fits anywhere
      2'd0:    mal = 1'b0;
      // half word needs an even address
      2'd1:    mal = req.adr[0];
      // full word needs offset zero
      2'd2:    mal = |req.adr[1:0];
      // siz 3 would exceed the bus width
      default: mal = 1'b1;
    endcase
  end

  ////////////////////
  // aligned address
  ////////////////////

  // clear the offset bits, the lanes carry the offset instead
  assign adr = {req.adr[`TCB_ADR_W-1:`TCB_OFS_W], ofs_t'(0)};

endmodule

// File: hw/tcb_lane_steer.sv
// TCB write lane steering
// moves reference-order write bytes onto memory lanes in little
// or big endian order and sets the byte enables of covered lanes

`timescale 1ns/1ns

`include "tcb_conv_consts.svh"

module tcb_lane_steer
  import tcb_pkg::*;
(
  input  tcb_req_t req,
  output ben_t     ben,
  output dat_t     wdt
);

  // byte views of the data words
  logic [`TCB_BEW-1:0][`TCB_SLW-1:0] ref_b;
  logic [`TCB_BEW-1:0][`TCB_SLW-1:0] lane_b;

  // transfer byte count, one bit wider than the offset
  logic [`TCB_OFS_W:0] cnt;
  // byte offset from the request address
  ofs_t ofs;

  assign ref_b = req.wdt;
  assign ofs   = req.adr[`TCB_OFS_W-1:0];

  // 2**siz, illegal siz treated as a full word
  // (such a request never reaches the memory anyway)
  always_comb begin
    case (req.siz)
      2'd0:    cnt = 3'd1;
      2'd1:    cnt = 3'd2;
      default: cnt = 3'd4;
    endcase
  end

  ////////////////////
  // lane multiplexer
  ////////////////////

  always_comb begin
    ofs_t rel;
    ofs_t sel;
    for (int i = 0; i < `TCB_BEW; i++) begin
      // lane position relative to the first covered lane
      rel = ofs_t'(i) - ofs;
      // little endian keeps order, big endian reverses it
      if (req.ndn) begin
        sel = ofs_t'(cnt - {1'b0, rel} - 3'd1);
      end else begin
        sel = rel;
      end
      lane_b[i] = ref_b[sel];
      // enable lanes ofs to ofs+cnt-1
      ben[i] = ({1'b0, rel} < cnt);
    end
  end

  assign wdt = lane_b;

endmodule

// File: hw/tcb_endian_conv.sv
// TCB reference to memory mode converter
// checks alignment, steers write lanes, drops misaligned requests
// and puts read data back into reference order one cycle later

`timescale 1ns/1ns

`include "tcb_conv_consts.svh"

module tcb_endian_conv
  import tcb_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // manager side, reference mode
  input  logic      vld,
  input  tcb_req_t  req,
  output tcb_rsp_t  rsp,
  // memory side, memory mode
  output logic      mvld,
  output tcb_mreq_t mreq,
  input  dat_t      mrsp_rdt
);

  // response context kept for the data phase
  typedef struct packed {
    logic wen;
    logic ndn;
    siz_t siz;
    ofs_t ofs;
  } ctx_t;

  // results of the two request-side blocks
  logic mal;
  adr_t adr_aln;
  ben_t ben_lane;
  dat_t wdt_lane;

  // registered context
  logic ctx_vld;
  logic ctx_err;
  ctx_t ctx;

  ////////////////////
  // request path
  ////////////////////

  // both blocks look at the same request in parallel
  tcb_align_check u_align (
    .req (req),
    .mal (mal),
    .adr (adr_aln)
  );

  tcb_lane_steer u_steer (
    .req (req),
    .ben (ben_lane),
    .wdt (wdt_lane)
  );

  // misaligned access never reaches the memory
  assign mvld = vld & ~mal;

  assign mreq.wen = req.wen;
  assign mreq.adr = adr_aln;
  assign mreq.ben = ben_lane;
  assign mreq.wdt = wdt_lane;

  ////////////////////
  // response context
  ////////////////////

  // valid and error flags
  always_ff @(posedge clk) begin
    if (reset) begin
      ctx_vld <= 1'b0;
      ctx_err <= 1'b0;
    end else begin
      ctx_vld <= vld;
      ctx_err <= vld & mal;
    end
  end

  // access shape, only meaningful next to ctx_vld
  always_ff @(posedge clk) begin
    if (vld) begin
      ctx.wen <= req.wen;
      ctx.ndn <= req.ndn;
      ctx.siz <= req.siz;
      ctx.ofs <= req.adr[`TCB_OFS_W-1:0];
    end
  end

  ////////////////////
  // read data unsteer
  ////////////////////

  logic [`TCB_BEW-1:0][`TCB_SLW-1:0] mem_b;
  logic [`TCB_BEW-1:0][`TCB_SLW-1:0] ref_b;

  assign mem_b = mrsp_rdt;

  always_comb begin
    logic [`TCB_OFS_W:0] cnt;
    ofs_t rel;
    ofs_t lane;
    case (ctx.siz)
      2'd0:    cnt = 3'd1;
      2'd1:    cnt = 3'd2;
      default: cnt = 3'd4;
    endcase
    for (int j = 0; j < `TCB_BEW; j++) begin
      // reverse of the write mapping
      if (ctx.ndn) begin
        rel = ofs_t'(cnt - 3'(j) - 3'd1);
      end else begin
        rel = ofs_t'(j);
      end
      lane = ctx.ofs + rel;
      // bytes beyond the transfer size read as zero
      if (3'(j) < cnt) begin
        ref_b[j] = mem_b[lane];
      end else begin
        ref_b[j] = '0;
      end
    end
  end

  // only a good read returns data
  assign rsp.rdt = (ctx_vld & ~ctx_err & ~ctx.wen) ? dat_t'(ref_b) : '0;
  assign rsp.err = ctx_err;

endmodule

// File: hw/tcb_mem_sub.sv
// TCB memory subordinate
// word array with byte-enabled writes and a registered read,
// response data valid one cycle after the request

`timescale 1ns/1ns

`include "tcb_conv_consts.svh"

module tcb_mem_sub
  import tcb_pkg::*;
(
  input  logic      clk,
  input  logic      mvld,
  input  tcb_mreq_t mreq,
  output dat_t      rdt
);

  localparam int WIDX_W = $clog2(`TCB_MEM_WORDS);

  // storage, contents undefined until written
  dat_t mem [`TCB_MEM_WORDS];

  // word index from the aligned byte address
  logic [WIDX_W-1:0] widx;

  assign widx = mreq.adr[`TCB_OFS_W +: WIDX_W];

  ////////////////////
  // write
  ////////////////////

  // only enabled lanes change
  always_ff @(posedge clk) begin
    if (mvld && mreq.wen) begin
      for (int b = 0; b < `TCB_BEW; b++) begin
        if (mreq.ben[b]) begin
          mem[widx][b*`TCB_SLW +: `TCB_SLW] <= mreq.wdt[b*`TCB_SLW +: `TCB_SLW];
        end
      end
    end
  end

  ////////////////////
  // read
  ////////////////////

  // one cycle delay, old data on a same-edge write
  always_ff @(posedge clk) begin
    if (mvld) begin
      rdt <= mem[widx];
    end
  end

endmodule

// File: hw/tcb_conv_top.sv
// TCB converter top
// reference mode port in front of a byte-enabled memory
// through the endianness and alignment converter

`timescale 1ns/1ns

module tcb_conv_top
  import tcb_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     vld,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  // memory side of the converter
  logic      mvld;
  tcb_mreq_t mreq;
  dat_t      mrsp_rdt;

  // converter
  tcb_endian_conv u_conv (
    .clk      (clk),
    .reset    (reset),
    .vld      (vld),
    .req      (req),
    .rsp      (rsp),
    .mvld     (mvld),
    .mreq     (mreq),
    .mrsp_rdt (mrsp_rdt)
  );

  // memory
  tcb_mem_sub u_mem (
    .clk  (clk),
    .mvld (mvld),
    .mreq (mreq),
    .rdt  (mrsp_rdt)
  );

endmodule

// File: verif/tcb_conv_chk.sv
// TCB converter checker
// concurrent assertions on memory request gating and on the
// timing of the response error flag

`timescale 1ns/1ns

module tcb_conv_chk
  import tcb_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     vld,
  input tcb_req_t req,
  input logic     mal,
  input logic     mvld,
  input tcb_rsp_t rsp
);

  // own view of an illegal access, size mask against the offset
  logic mis;

  assign mis = (req.siz == 2'd3) ||
               ((req.adr[1:0] & ofs_t'((1 << req.siz) - 1)) != '0);

  // alignment block flags exactly the illegal accesses
  a_mal_decode: assert property (@(posedge clk) disable iff (reset)
    vld |-> (mal == mis))
    else $error("misalignment flag disagrees with the size and offset");

  // misaligned request never reaches the memory
  a_mal_gate: assert property (@(posedge clk) mis |-> !mvld)
    else $error("memory request issued for a misaligned access");

  // memory side quiet in reset
  a_reset_quiet: assert property (@(posedge clk) reset |-> !mvld)
    else $error("memory request issued during reset");

  // err one cycle after vld is the misalignment of that request
  a_err_timing: assert property (@(posedge clk) disable iff (reset)
    vld |=> (rsp.err == $past(mis)))
    else $error("response err does not follow the registered misalignment");

endmodule

// every converter instance gets a checker
bind tcb_endian_conv tcb_conv_chk u_chk (
  .clk   (clk),
  .reset (reset),
  .vld   (vld),
  .req   (req),
  .mal   (mal),
  .mvld  (mvld),
  .rsp   (rsp)
);

// File: verif/tcb_conv_tb.sv
// TCB converter testbench
// table-driven accesses through the converter top, compared with a
// byte-array memory model, then random back-to-back traffic

`timescale 1ns/1ns

`include "tcb_conv_consts.svh"

module tcb_conv_tb
  import tcb_pkg::*;
();

  localparam int RST_CYCLES  = 16;
  localparam int RSP_TIMEOUT = 8;
  localparam int NUM_ROWS    = 28;
  localparam int NUM_RAND    = 24;

  // table column values
  localparam logic WR  = 1'b1;
  localparam logic RD  = 1'b0;
  localparam logic LE  = 1'b0;
  localparam logic BE  = 1'b1;
  localparam logic OK  = 1'b0;
  localparam logic ERR = 1'b1;
  localparam siz_t B1  = 2'd0;
  localparam siz_t B2  = 2'd1;
  localparam siz_t B4  = 2'd2;
  localparam siz_t BX  = 2'd3;

  // one stimulus row, err is the expected response flag
  typedef struct packed {
    logic wen;
    logic ndn;
    siz_t siz;
    adr_t adr;
    logic err;
  } row_t;

  logic     clk;
  logic     reset;
  logic     vld;
  tcb_req_t req;
  tcb_rsp_t rsp;

  // memory model, one entry per byte
  logic [`TCB_SLW-1:0] mdl [`TCB_MEM_WORDS*`TCB_BEW];

  int   checks;
  int   errors;
  int   tests;
  int   bad_tests;
  logic hung;

  row_t tbl [NUM_ROWS] = '{
    // 0..13 little endian, every legal offset per size
    '{WR, LE, B1, 16'h000c, OK},
    '{RD, LE, B1, 16'h000c, OK},
    '{WR, LE, B1, 16'h000d, OK},
    '{RD, LE, B1, 16'h000d, OK},
    '{WR, LE, B1, 16'h000e, OK},
    '{RD, LE, B1, 16'h000e, OK},
    '{WR, LE, B1, 16'h000f, OK},
    '{RD, LE, B1, 16'h000f, OK},
    '{WR, LE, B2, 16'h0004, OK},
    '{RD, LE, B2, 16'h0004, OK},
    '{WR, LE, B2, 16'h0006, OK},
    '{RD, LE, B2, 16'h0006, OK},
    '{WR, LE, B4, 16'h0008, OK},
    '{RD, LE, B4, 16'h0008, OK},
    // 14..18 big endian writes, seen from both sides
    '{WR, BE, B4, 16'h0010, OK},
    '{RD, LE, B4, 16'h0010, OK},
    '{WR, BE, B2, 16'h0016, OK},
    '{RD, LE, B2, 16'h0016, OK},
    '{RD, BE, B2, 16'h0016, OK},
    // 19..22 single bytes into prefilled word 0x20
    '{WR, LE, B1, 16'h0021, OK},
    '{RD, LE, B4, 16'h0020, OK},
    '{WR, BE, B1, 16'h0023, OK},
    '{RD, BE, B4, 16'h0020, OK},
    // 23..27 rejected accesses, then word 0x30 untouched
    '{RD, LE, B2, 16'h0031, ERR},
    '{WR, LE, B2, 16'h0033, ERR},
    '{WR, BE, B4, 16'h0032, ERR},
    '{WR, LE, BX, 16'h0030, ERR},
    '{RD, LE, B4, 16'h0030, OK}
  };

  tcb_conv_top u_tcb_conv_top (
    .clk   (clk),
    .reset (reset),
    .vld   (vld),
    .req   (req),
    .rsp   (rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////

  // size rule, siz 3 never legal
  function automatic logic expect_mal(siz_t siz, adr_t adr);
    ofs_t mask;
    mask = ofs_t'((1 << siz) - 1);
    return (siz == 2'd3) || ((adr[1:0] & mask) != 2'd0);
  endfunction

  // applies a write to the model or forms the read response
  function automatic tcb_rsp_t model_access(row_t row, dat_t wdt);
    tcb_rsp_t want;
    int s;
    int o;
    int base;
    int lane;
    want = '0;
    want.err = row.err;
    if (!row.err) begin
      s = 1 << row.siz;
      o = int'(row.adr[1:0]);
      base = int'(row.adr[9:2]) * 4;
      for (int i = 0; i < s; i++) begin
        // big endian puts byte i on lane o+s-1-i
        lane = row.ndn ? o + s - 1 - i : o + i;
        if (row.wen) begin
          mdl[base + lane] = wdt[8*i +: 8];
        end else begin
          want.rdt[8*i +: 8] = mdl[base + lane];
        end
      end
    end
    return want;
  endfunction

  task automatic check_rsp(tcb_rsp_t got, tcb_rsp_t want, string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t ns: %s gave rdt %h err %b, expected rdt %h err %b",
               $time, what, got.rdt, got.err, want.rdt, want.err);
    end
  endtask

  ////////////////////
  // bus access
  ////////////////////

  // response cycle marked by the converter context flag
  task automatic await_rsp();
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < RSP_TIMEOUT) begin
      @(negedge clk);
      n++;
      seen = u_tcb_conv_top.u_conv.ctx_vld;
    end
    if (!seen) begin
      hung = 1'b1;
      $display("no response from the converter within %0d cycles at %0t ns",
               RSP_TIMEOUT, $time);
    end
  endtask

  task automatic single_access(row_t row, string what);
    dat_t     wdt;
    tcb_rsp_t want;
    wdt = $urandom();
    @(posedge clk);
    #1;
    vld = 1'b1;
    req = '{wen: row.wen, ndn: row.ndn, siz: row.siz, adr: row.adr, wdt: wdt};
    want = model_access(row, wdt);
    // one cycle strobe
    @(posedge clk);
    #1;
    vld = 1'b0;
    await_rsp();
    if (!hung) begin
      check_rsp(rsp, want, what);
    end
  endtask

  task automatic finish_test(string name, int err0);
    tests++;
    if (errors != err0 || hung) begin
      bad_tests++;
    end
    $display("%s: %0d mismatches", name, errors - err0);
  endtask

  task automatic run_rows(int lo, int hi, string name);
    int err0;
    err0 = errors;
    for (int k = lo; k <= hi && !hung; k++) begin
      single_access(tbl[k], $sformatf("%s row %0d", name, k));
    end
    finish_test(name, err0);
  endtask

  // new row every cycle, response of the previous one checked
  task automatic back_to_back();
    row_t     row;
    dat_t     wdt;
    tcb_rsp_t want_q[$];
    int       err0;
    err0 = errors;
    for (int k = 0; k <= NUM_RAND && !hung; k++) begin
      @(posedge clk);
      #1;
      if (k < NUM_RAND) begin
        row.wen = 1'($urandom_range(1));
        row.ndn = 1'($urandom_range(1));
        row.siz = siz_t'($urandom_range(3));
        // words 0..15 all written by the prefill
        row.adr = adr_t'($urandom_range(63));
        row.err = expect_mal(row.siz, row.adr);
        wdt = $urandom();
        vld = 1'b1;
        req = '{wen: row.wen, ndn: row.ndn, siz: row.siz, adr: row.adr, wdt: wdt};
        want_q.push_back(model_access(row, wdt));
      end else begin
        vld = 1'b0;
      end
      if (k > 0) begin
        await_rsp();
        if (!hung) begin
          check_rsp(rsp, want_q.pop_front(), $sformatf("random row %0d", k - 1));
        end
      end
    end
    finish_test("back_to_back", err0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int   err0;
    row_t fill;
    void'($urandom(32'h61509a81));
    reset = 1'b1;
    vld = 1'b0;
    req = '0;
    hung = 1'b0;
    checks = 0;
    errors = 0;
    tests = 0;
    bad_tests = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle response straight out of reset
    err0 = errors;
    @(negedge clk);
    check_rsp(rsp, tcb_rsp_t'(0), "idle after reset");
    finish_test("reset", err0);
    // known contents in words 0..15
    err0 = errors;
    for (int w = 0; w < 16 && !hung; w++) begin
      fill = '{WR, LE, B4, adr_t'(w * 4), OK};
      single_access(fill, $sformatf("prefill word %0d", w));
    end
    finish_test("prefill", err0);
    run_rows(0, 13, "le_round_trip");
    run_rows(14, 18, "be_cross_view");
    run_rows(19, 22, "byte_enables");
    run_rows(23, 27, "misalign_reject");
    back_to_back();
    $display("%0d tests, %0d failing, %0d checks, %0d mismatches",
             tests, bad_tests, checks, errors);
    if (hung || errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

// File: tcb_conv_top.f
+incdir+hw
hw/tcb_pkg.sv
hw/tcb_align_check.sv
hw/tcb_lane_steer.sv
hw/tcb_endian_conv.sv
hw/tcb_mem_sub.sv
hw/tcb_conv_top.sv
verif/tcb_conv_chk.sv
verif/tcb_conv_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the TCB converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tcb_conv_top.f \
  --top-module tcb_conv_tb -Mdir "$BUILD" -o tcb_conv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/tcb_conv_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
